//--- dv/mlu_tb.sv
`timescale 1ns/1ns
`include "mlu_defs.svh"

module mlu_tb;

  localparam int RANDOM_TESTS = 200;
  localparam int CLK_PERIOD   = 40;
  localparam int LATENCY      = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  mlu_pkg::mlu_op_e      op;
  logic [`MLU_WIDTH-1:0] a;
  logic [`MLU_WIDTH-1:0] b;
  logic                  carry_in;
  logic                  result_valid;
  logic [`MLU_WIDTH-1:0] result;
  logic                  carry_out;
  logic                  zero;
  logic                  negative;
  logic                  overflow;

  // Directed tests as read from the data file.
  string                 dir_name[$];
  logic [2:0]            dir_op[$];
  logic [`MLU_WIDTH-1:0] dir_a[$];
  logic [`MLU_WIDTH-1:0] dir_b[$];
  logic                  dir_cin[$];
  logic [`MLU_WIDTH-1:0] dir_result[$];
  logic [3:0]            dir_flags[$];

  // Operations in flight with the oldest at the front.
  string                 exp_name[$];
  logic [`MLU_WIDTH-1:0] exp_result[$];
  logic [3:0]            exp_flags[$];
  int                    exp_cycle[$];

  int          cycle = 0;
  int          errors;
  int          tests_done;
  int          tests_failed;
  int          total_tests;
  logic [31:0] lcg_state;

  mlu_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .op           (op),
    .a            (a),
    .b            (b),
    .carry_in     (carry_in),
    .result_valid (result_valid),
    .result       (result),
    .carry_out    (carry_out),
    .zero         (zero),
    .negative     (negative),
    .overflow     (overflow)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Returns {value, carry, zero, negative, overflow} for one operation.
  function automatic logic [`MLU_WIDTH+3:0] model_op(
    input logic [2:0]            code,
    input logic [`MLU_WIDTH-1:0] op_a,
    input logic [`MLU_WIDTH-1:0] op_b,
    input logic                  cin
  );
    logic [`MLU_WIDTH:0]   sum;
    logic [`MLU_WIDTH-1:0] b_eff;
    logic [`MLU_WIDTH-1:0] value;
    logic                  carry;
    logic                  ovf;
    carry = 1'b0;
    ovf   = 1'b0;
    case (code)
      3'd0, 3'd1: begin
        b_eff = (code == 3'd1) ? ~op_b : op_b; // With cin at 1 this is a - b.
        sum   = {1'b0, op_a} + {1'b0, b_eff} + cin;
        value = sum[`MLU_WIDTH-1:0];
        carry = sum[`MLU_WIDTH];
        ovf   = (op_a[`MLU_WIDTH-1] == b_eff[`MLU_WIDTH-1]) &&
                (value[`MLU_WIDTH-1] != op_a[`MLU_WIDTH-1]);
      end
      3'd2:    value = op_a & op_b;
      3'd3:    value = op_a | op_b;
      3'd4:    value = op_a ^ op_b;
      3'd5:    value = ~op_a;
      default: value = '0;
    endcase
    return {value, carry, (value == '0), value[`MLU_WIDTH-1], ovf};
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic load_tests(output bit ok);
    int                    fd;
    int                    count;
    int                    ch;
    string                 name;
    logic [2:0]            t_op;
    logic [`MLU_WIDTH-1:0] t_a;
    logic [`MLU_WIDTH-1:0] t_b;
    logic                  t_cin;
    logic [`MLU_WIDTH-1:0] t_res;
    logic [3:0]            t_flags;
    ok = 1'b0;
    fd = $fopen("dv/mlu_tests.dat", "r");
    if (fd == 0) begin
      $display("Cannot open dv/mlu_tests.dat for reading");
      return;
    end
    while (!$feof(fd)) begin
      count = $fscanf(fd, "%s", name);
      if (count == 1) begin
        if (name[0] == "#") begin
          do begin
            ch = $fgetc(fd); // Skip the rest of a comment line.
          end while (ch != "\n" && ch != -1);
        end else begin
          count = $fscanf(fd, "%h %h %h %h %h %h", t_op, t_a, t_b, t_cin, t_res, t_flags);
          if (count == 6) begin
            dir_name.push_back(name);
            dir_op.push_back(t_op);
            dir_a.push_back(t_a);
            dir_b.push_back(t_b);
            dir_cin.push_back(t_cin);
            dir_result.push_back(t_res);
            dir_flags.push_back(t_flags);
          end else begin
            $display("Test %s in dv/mlu_tests.dat has missing or bad fields", name);
            errors++;
          end
        end
      end
    end
    $fclose(fd);
    ok = (dir_name.size() > 0);
  endtask

  task automatic issue_op(input string name, input logic [2:0] code,
                          input logic [`MLU_WIDTH-1:0] op_a, input logic [`MLU_WIDTH-1:0] op_b,
                          input logic cin, input logic [`MLU_WIDTH-1:0] exp_res,
                          input logic [3:0] exp_flg);
    start    = 1'b1;
    op       = mlu_pkg::mlu_op_e'(code);
    a        = op_a;
    b        = op_b;
    carry_in = cin;
    exp_name.push_back(name);
    exp_result.push_back(exp_res);
    exp_flags.push_back(exp_flg);
    exp_cycle.push_back(cycle); // Cycle in which the strobe is presented.
  endtask

  task automatic collect_result();
    string name;
    int    errors_before;
    int    issued;
    if (result_valid !== 1'b1) begin
      return;
    end
    if (exp_name.size() == 0) begin
      $display("result_valid went high at cycle %0d with no operation in flight", cycle);
      errors++;
      return;
    end
    name          = exp_name.pop_front();
    issued        = exp_cycle.pop_front();
    errors_before = errors;
    check_value(name, "latency", LATENCY, cycle - issued);
    check_value(name, "result", exp_result.pop_front(), result);
    check_value(name, "flags", exp_flags.pop_front(), {carry_out, zero, negative, overflow});
    tests_done++;
    if (errors == errors_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s", name);
    end
  endtask

  // Outputs are looked at on the falling edge, then the next inputs go out.
  task automatic next_cycle();
    @(negedge clk);
    collect_result();
    start = 1'b0;
  endtask

  initial begin
    bit                    loaded;
    logic [31:0]           r;
    logic [2:0]            code;
    logic [`MLU_WIDTH-1:0] rand_a;
    logic [`MLU_WIDTH-1:0] rand_b;
    logic                  cin;
    logic [`MLU_WIDTH+3:0] expected;
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    op           = mlu_pkg::MLU_ADD;
    a            = '0;
    b            = '0;
    carry_in     = 1'b0;
    errors       = 0;
    tests_done   = 0;
    tests_failed = 0;
    lcg_state    = 32'd64892;
    load_tests(loaded);
    if (!loaded) begin
      $display("No directed tests could be loaded from dv/mlu_tests.dat");
      $display("Done: errors found");
      $finish;
    end else begin
      total_tests = dir_name.size() + RANDOM_TESTS;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_value("reset", "result_valid", 0, result_valid);

      for (int i = 0; i < dir_name.size(); i++) begin
        next_cycle();
        issue_op(dir_name[i], dir_op[i], dir_a[i], dir_b[i], dir_cin[i],
                 dir_result[i], dir_flags[i]);
      end
      repeat (3) next_cycle(); // Idle gap in which nothing may come out.

      for (int i = 0; i < RANDOM_TESTS; i++) begin
        next_cycle();
        r        = lcg_next();
        code     = r[31:29];
        r        = lcg_next();
        rand_a   = r[31:16];
        r        = lcg_next();
        rand_b   = r[31:16];
        cin      = r[15];
        expected = model_op(code, rand_a, rand_b, cin);
        issue_op($sformatf("random_%0d", i), code, rand_a, rand_b, cin,
                 expected[`MLU_WIDTH+3:4], expected[3:0]);
      end
      next_cycle();
      while (exp_name.size() > 0) begin
        next_cycle();
      end
      repeat (2) next_cycle();

      if (tests_done != total_tests) begin
        $display("Only %0d of %0d tests produced a result", tests_done, total_tests);
        errors++;
      end
      $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
               tests_done, tests_done - tests_failed, tests_failed, errors);
      if (errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

  initial begin
    wait (total_tests > 0);
    #((total_tests + 20) * CLK_PERIOD);
    $display("Watchdog expired: results stopped arriving with %0d operations in flight",
             exp_name.size());
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- dv/mlu_tests.dat
# name op a b carry_in result flags, all values in hex
# op 0 add 1 sub 2 and 3 or 4 xor 5 not 6 nop0 7 nop1, flags are carry zero negative overflow
add_simple 0 0003 0004 0 0007 0
add_cin 0 0003 0004 1 0008 0
add_nib0_carry 0 000F 0001 0 0010 0
add_nib1_carry 0 00FF 0001 0 0100 0
add_nib2_carry 0 0FFF 0001 0 1000 0
add_wrap 0 FFFF 0001 0 0000 C
add_cin_wrap 0 FFFF 0000 1 0000 C
add_ovf_pos 0 7FFF 0001 0 8000 3
add_ovf_neg 0 8000 8000 0 0000 D
add_negative 0 FFFE 0001 0 FFFF 2
add_no_carry 0 1234 4321 0 5555 0
add_cin_chain 0 0FFF 0000 1 1000 0
add_zero 0 0000 0000 0 0000 4
add_nib3_carry 0 F000 1000 0 0000 C
sub_simple 1 0009 0004 1 0005 8
sub_equal 1 1234 1234 1 0000 C
sub_borrow 1 0004 0009 1 FFFB 2
sbb_simple 1 0009 0004 0 0004 8
sbb_equal 1 0005 0005 0 FFFF 2
sub_ovf_neg 1 8000 0001 1 7FFF 9
sub_ovf_pos 1 7FFF FFFF 1 8000 3
sub_from_zero 1 0000 0001 1 FFFF 2
sub_nibble_borrow 1 1000 0001 1 0FFF 8
sub_max 1 FFFF 0001 1 FFFE A
and_mix 2 F0F0 FF00 0 F000 2
and_zero 2 AAAA 5555 0 0000 4
and_cin 2 FFFF FFFF 1 FFFF 2
or_mix 3 F000 000F 0 F00F 2
or_zero 3 0000 0000 1 0000 4
or_positive 3 1234 0808 0 1A3C 0
xor_mix 4 FFFF 0F0F 0 F0F0 2
xor_self 4 5A5A 5A5A 0 0000 4
xor_positive 4 1234 0FFF 1 1DCB 0
not_zero 5 0000 1234 0 FFFF 2
not_ones 5 FFFF 0000 1 0000 4
not_positive 5 8F0F 0000 0 70F0 0
nop0_plain 6 1234 5678 0 0000 4
nop0_cin 6 FFFF FFFF 1 0000 4
nop1_plain 7 1234 5678 0 0000 4
nop1_cin 7 8000 8000 1 0000 4

//--- logic/carry_lookahead.sv
`timescale 1ns/1ns
`include "mlu_defs.svh"

module carry_lookahead (
  input  logic [`MLU_SLICES-1:0] prop,
  input  logic [`MLU_SLICES-1:0] gen,
  input  logic                   carry_in,
  output logic [`MLU_SLICES-1:0] carry,
  output logic                   carry_out
);

  logic [`MLU_SLICES:0] c;

  // Each carry is a flat sum of products: carry_in through every lower
  // propagate, or some lower generate through the propagates above it.
  always_comb begin
    logic term;
    for (int i = 0; i <= `MLU_SLICES; i++) begin
      term = carry_in;
      for (int j = 0; j < i; j++) begin
        term = term & prop[j];
      end
      c[i] = term;
      for (int k = 0; k < i; k++) begin
        term = gen[k];
        for (int j = k + 1; j < i; j++) begin
          term = term & prop[j];
        end
        c[i] = c[i] | term;
      end
    end
  end

  assign carry     = c[`MLU_SLICES-1:0];
  assign carry_out = c[`MLU_SLICES];

  // A slice cannot both pass and make a carry, the slice sum rules it out.
  always_comb begin
    assert final ((prop & gen) == '0)
      else $error("carry_lookahead: propagate and generate both high in a slice");
  end

endmodule

//--- logic/mlu_core.sv
`timescale 1ns/1ns
`include "mlu_defs.svh"

module mlu_core (
  input  mlu_pkg::mlu_op_e      op,
  input  logic [`MLU_WIDTH-1:0] a,
  input  logic [`MLU_WIDTH-1:0] b,
  input  logic                  carry_in,
  output logic [`MLU_WIDTH-1:0] result,
  output mlu_pkg::mlu_flags_t   flags
);

  localparam int MSB = `MLU_WIDTH - 1;

  logic [`MLU_SLICES-1:0] prop;
  logic [`MLU_SLICES-1:0] gen;
  logic [`MLU_SLICES-1:0] slice_zero;
  logic [`MLU_SLICES-1:0] slice_carry;
  logic                   carry_out;
  logic                   is_arith;
  logic                   sign_b;

  for (genvar i = 0; i < `MLU_SLICES; i++) begin : g_slice
    mlu_slice u_slice (
      .a        (a[i*`MLU_SLICE_WIDTH +: `MLU_SLICE_WIDTH]),
      .b        (b[i*`MLU_SLICE_WIDTH +: `MLU_SLICE_WIDTH]),
      .op       (op),
      .carry_in (slice_carry[i]),
      .out      (result[i*`MLU_SLICE_WIDTH +: `MLU_SLICE_WIDTH]),
      .prop     (prop[i]),
      .gen      (gen[i]),
      .zero     (slice_zero[i])
    );
  end

  carry_lookahead u_lookahead (
    .prop      (prop),
    .gen       (gen),
    .carry_in  (carry_in),
    .carry     (slice_carry),
    .carry_out (carry_out)
  );

  assign is_arith = (op == mlu_pkg::MLU_ADD) || (op == mlu_pkg::MLU_SUB);

  // Sign of the operand the adder really sees.
  assign sign_b = (op == mlu_pkg::MLU_SUB) ? ~b[MSB] : b[MSB];

  assign flags.carry    = carry_out; // Logic ops give no prop or gen, so this stays 0.
  assign flags.zero     = &slice_zero;
  assign flags.negative = result[MSB];

  // Two like-signed operands giving an opposite-signed sum.
  assign flags.overflow = is_arith && (a[MSB] == sign_b) && (result[MSB] != a[MSB]);

endmodule

//--- logic/mlu_defs.svh
`ifndef MLU_DEFS_SVH
`define MLU_DEFS_SVH

// Bits handled by one slice of the datapath.
`define MLU_SLICE_WIDTH 4

// Number of slices chained through the lookahead unit.
`define MLU_SLICES 4

// Full data width of the unit.
`define MLU_WIDTH (`MLU_SLICE_WIDTH * `MLU_SLICES)

// Opcode width, enough for all eight functions.
`define MLU_OP_WIDTH 3

`endif

//--- logic/mlu_pkg.sv
`include "mlu_defs.svh"

package mlu_pkg;

  // The encoding order matters, the testbench data file uses the raw codes.
  typedef enum logic [`MLU_OP_WIDTH-1:0] {
    MLU_ADD,
    MLU_SUB,
    MLU_AND,
    MLU_OR,
    MLU_XOR,
    MLU_NOT,
    MLU_NOP0,
    MLU_NOP1
  } mlu_op_e;

  typedef struct packed {
    mlu_op_e               op;
    logic [`MLU_WIDTH-1:0] a;
    logic [`MLU_WIDTH-1:0] b;
    logic                  carry_in;
  } mlu_issue_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic negative;
    logic overflow;  // Signed overflow, add and subtract only.
  } mlu_flags_t;

  typedef struct packed {
    logic [`MLU_WIDTH-1:0] value;
    mlu_flags_t            flags;
  } mlu_result_t;

endpackage

//--- logic/mlu_slice.sv
`timescale 1ns/1ns
`include "mlu_defs.svh"

module mlu_slice (
  input  logic [`MLU_SLICE_WIDTH-1:0] a,
  input  logic [`MLU_SLICE_WIDTH-1:0] b,
  input  mlu_pkg::mlu_op_e            op,
  input  logic                        carry_in,
  output logic [`MLU_SLICE_WIDTH-1:0] out,
  output logic                        prop,
  output logic                        gen,
  output logic                        zero
);

  logic [`MLU_SLICE_WIDTH-1:0] b_eff;
  logic [`MLU_SLICE_WIDTH:0]   raw_sum;
  logic [`MLU_SLICE_WIDTH:0]   full_sum;
  logic                        is_arith;

  assign is_arith = (op == mlu_pkg::MLU_ADD) || (op == mlu_pkg::MLU_SUB);

  // Subtract adds the inverted operand and takes the +1 from carry_in.
  assign b_eff = (op == mlu_pkg::MLU_SUB) ? ~b : b;

  // The carry-free sum decides propagate and generate, so neither
  // depends on carry_in and the lookahead has no loop through the slice.
  assign raw_sum = {1'b0, a} + {1'b0, b_eff};

  assign full_sum = raw_sum + {{`MLU_SLICE_WIDTH{1'b0}}, carry_in};

  always_comb begin
    prop = 1'b0;
    gen  = 1'b0;
    case (op)
      mlu_pkg::MLU_ADD,
      mlu_pkg::MLU_SUB: begin
        out  = a + b_eff + {{(`MLU_SLICE_WIDTH-1){1'b0}}, carry_in};
        prop = (raw_sum[`MLU_SLICE_WIDTH-1:0] == '1); // Passes an incoming carry on.
        gen  = raw_sum[`MLU_SLICE_WIDTH];             // Makes a carry by itself.
      end
      mlu_pkg::MLU_AND: begin
        out = a & b;
      end
      mlu_pkg::MLU_OR: begin
        out = a | b;
      end
      mlu_pkg::MLU_XOR: begin
        out = a ^ b;
      end
      mlu_pkg::MLU_NOT: begin
        out = ~a;
      end
      default: begin
        out = '0; // Both NOP codes.
      end
    endcase
  end

  assign zero = (out == '0);

  // The lookahead forms this nibble's carry out from prop and gen alone.
  always_comb begin
    assert final (!is_arith ||
                  (full_sum[`MLU_SLICE_WIDTH] == (gen | (prop & carry_in))))
      else $error("mlu_slice: propagate and generate disagree with the nibble carry");
  end

endmodule

//--- logic/mlu_stage.sv
`timescale 1ns/1ns
`include "mlu_defs.svh"

module mlu_stage #(
  parameter type payload_t = logic [`MLU_WIDTH-1:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t data,
  output logic     valid,
  output payload_t q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= load; // One strobe out per strobe in.
    end
  end

  // Holds its contents between loads.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (load) begin
      q <= data;
    end
  end

  // Nothing may come out of the stage on the first edge after reset.
  assert property (@(posedge clk) $rose(rst_n) |-> !valid)
    else $error("mlu_stage: valid high on the first clock after reset");

endmodule

//--- logic/mlu_top.sv
`timescale 1ns/1ns
`include "mlu_defs.svh"

module mlu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  mlu_pkg::mlu_op_e      op,
  input  logic [`MLU_WIDTH-1:0] a,
  input  logic [`MLU_WIDTH-1:0] b,
  input  logic                  carry_in,
  output logic                  result_valid,
  output logic [`MLU_WIDTH-1:0] result,
  output logic                  carry_out,
  output logic                  zero,
  output logic                  negative,
  output logic                  overflow
);

  mlu_pkg::mlu_issue_t   issue_d;
  mlu_pkg::mlu_issue_t   issue_q;
  logic                  issue_valid;
  logic [`MLU_WIDTH-1:0] core_result;
  mlu_pkg::mlu_flags_t   core_flags;
  mlu_pkg::mlu_result_t  result_d;
  mlu_pkg::mlu_result_t  result_q;

  assign issue_d = '{op: op, a: a, b: b, carry_in: carry_in};

  mlu_stage #(.payload_t(mlu_pkg::mlu_issue_t)) issue_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (start),
    .data  (issue_d),
    .valid (issue_valid),
    .q     (issue_q)
  );

  mlu_core u_core (
    .op       (issue_q.op),
    .a        (issue_q.a),
    .b        (issue_q.b),
    .carry_in (issue_q.carry_in),
    .result   (core_result),
    .flags    (core_flags)
  );

  assign result_d = '{value: core_result, flags: core_flags};

  // Second register, so a result appears two edges after its start.
  mlu_stage #(.payload_t(mlu_pkg::mlu_result_t)) result_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (issue_valid),
    .data  (result_d),
    .valid (result_valid),
    .q     (result_q)
  );

  assign result    = result_q.value;
  assign carry_out = result_q.flags.carry;
  assign zero      = result_q.flags.zero;
  assign negative  = result_q.flags.negative;
  assign overflow  = result_q.flags.overflow;

endmodule

//--- vlog.f
+incdir+logic
logic/mlu_pkg.sv
logic/mlu_slice.sv
logic/carry_lookahead.sv
logic/mlu_stage.sv
logic/mlu_core.sv
logic/mlu_top.sv
dv/mlu_tb.sv
